/* list.f */
rtl/dcache_pkg.sv
rtl/dcache_if.sv
rtl/dcache_lookup.sv
rtl/dcache_data.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/mem_model.sv
verification/dcache_tb.sv

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    stage_if.monitor          stage,
    fill_if.driver            fill,
    output logic              mem_rd,
    output logic              mem_wr,
    output logic [addr_w-1:0] mem_addr,
    input  logic              mem_ack,
    output logic              busy,
    output logic              flush_done
);

    ctrl_state_e        state;
    ctrl_state_e        state_nxt;
    logic [index_w-1:0] walk;
    logic               walk_last;
    logic               walk_step;
    logic [index_w-1:0] addr_index;
    logic [tag_w-1:0]   addr_tag;

    assign walk_last = (walk == index_w'(num_lines - 1));

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (stage.miss) begin
                    state_nxt = stage.dirty ? st_wback : st_fill;
                end else if (flush) begin
                    state_nxt = st_flush_scan;
                end
            end
            st_wback: begin
                if (mem_ack) state_nxt = st_fill;
            end
            st_fill: begin
                if (mem_ack) state_nxt = st_replay;
            end
            st_replay: state_nxt = st_idle;
            st_flush_scan: begin
                if (stage.dirty) begin
                    state_nxt = st_flush_wback;
                end else if (walk_last) begin
                    state_nxt = st_flush_clear;
                end
            end
            st_flush_wback: begin
                if (mem_ack) state_nxt = walk_last ? st_flush_clear : st_flush_scan;
            end
            st_flush_clear: state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // walk counter wraps back to zero after the last index.
    assign walk_step = ((state == st_flush_scan) && !stage.dirty) ||
                       ((state == st_flush_wback) && mem_ack);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            walk <= '0;
        end else if (walk_step) begin
            walk <= walk + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////////////

    // busy rises with the miss itself, before the state moves.
    assign busy       = (state != st_idle) || stage.miss;
    assign mem_rd     = (state == st_fill);
    assign mem_wr     = (state == st_wback) || (state == st_flush_wback);
    assign flush_done = (state == st_flush_clear);

    assign fill.stall      = busy;
    assign fill.index_sel  = (state == st_flush_scan) || (state == st_flush_wback);
    assign fill.walk_index = walk;
    assign fill.tag_wr     = (state == st_fill) && mem_ack;
    assign fill.line_wr    = (state == st_fill) && mem_ack;
    assign fill.dirty_clr  = mem_ack && ((state == st_fill) || (state == st_flush_wback));
    assign fill.inval_all  = (state == st_flush_clear);
    assign fill.replay     = (state == st_replay);

    // write-backs use the stored tag, fills the request tag.
    assign addr_index = fill.index_sel ? walk : stage.index;
    assign addr_tag   = mem_wr ? stage.stored_tag : stage.tag;
    assign mem_addr   = {addr_tag, addr_index, {(offset_w + byte_off_w){1'b0}}};

endmodule

`default_nettype wire

/* rtl/dcache_data.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    stage_if.consumer         stage,
    fill_if.array             fill,
    input  logic [line_w-1:0] mem_rdata,
    output logic [word_w-1:0] rdata,
    output logic              done,
    output logic [line_w-1:0] victim_line
);

    logic [line_w-1:0]  lines [num_lines];
    logic [index_w-1:0] idx;
    logic [line_w-1:0]  cur_line;
    logic               rd_hit;
    logic               wr_hit;

    assign idx      = fill.index_sel ? fill.walk_index : stage.index;
    assign cur_line = lines[idx];

    assign rd_hit = stage.vld && stage.hit && (stage.op == op_load);
    assign wr_hit = stage.vld && stage.hit && (stage.op == op_store);

    ////////////////////////////////////////////////////////////////////////////
    // line storage
    ////////////////////////////////////////////////////////////////////////////

    // a fill and a store hit never fall in the same cycle.
    always_ff @(posedge clk) begin
        if (fill.line_wr) begin
            lines[idx] <= mem_rdata;
        end else if (wr_hit) begin
            lines[idx][stage.offset*word_w +: word_w] <= stage.wdata;
        end
    end

    // victim read-out for write-back, the memory samples it with mem_wr.
    assign victim_line = cur_line;

    ////////////////////////////////////////////////////////////////////////////
    // load return
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rd_hit) begin
            rdata <= cur_line[stage.offset*word_w +: word_w];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done <= 1'b0;
        end else begin
            done <= stage.vld && stage.hit;
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one request from the lookup stage to the data stage.
interface stage_if import dcache_pkg::*; ();
    logic                vld;
    opcode_e             op;
    logic [index_w-1:0]  index;
    logic [offset_w-1:0] offset;
    logic [word_w-1:0]   wdata;
    logic                hit;
    logic                miss;
    logic [tag_w-1:0]    tag;
    logic                dirty;
    logic [tag_w-1:0]    stored_tag;

    modport producer (output vld, op, index, offset, wdata, hit, miss, tag, dirty, stored_tag);
    modport consumer (input vld, op, index, offset, wdata, hit);
    // the controller only watches the miss and the line state.
    modport monitor (input miss, index, tag, dirty, stored_tag);
endinterface

// array updates and pipeline control from the controller.
interface fill_if import dcache_pkg::*; ();
    logic               stall;
    logic               index_sel;
    logic [index_w-1:0] walk_index;
    logic               tag_wr;
    logic               line_wr;
    logic               dirty_clr;
    logic               inval_all;
    logic               replay;

    modport driver (output stall, index_sel, walk_index, tag_wr, line_wr, dirty_clr,
                    inval_all, replay);
    modport array (input stall, index_sel, walk_index, tag_wr, line_wr, dirty_clr,
                   inval_all, replay);
endinterface

`default_nettype wire

/* rtl/dcache_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  opcode_e           opcode,
    input  logic [addr_w-1:0] addr,
    input  logic [word_w-1:0] wdata,
    stage_if.producer         stage,
    fill_if.array             fill
);

    logic [tag_w-1:0]    tag_mem [num_lines];
    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;

    logic                r_vld;
    opcode_e             r_op;
    logic [tag_w-1:0]    r_tag;
    logic [index_w-1:0]  r_index;
    logic [offset_w-1:0] r_offset;
    logic [word_w-1:0]   r_wdata;

    logic [index_w-1:0]  idx;
    logic                hit;
    logic                mem_op;

    assign mem_op = (opcode == op_load) || (opcode == op_store);

    ////////////////////////////////////////////////////////////////////////////
    // request register
    ////////////////////////////////////////////////////////////////////////////

    // a missed request drops vld but keeps its fields until the replay.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            r_vld <= 1'b0;
        end else if (fill.replay) begin
            r_vld <= 1'b1;
        end else if (fill.stall) begin
            r_vld <= 1'b0;
        end else begin
            r_vld <= req && mem_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!fill.stall && req) begin
            r_op     <= opcode;
            r_tag    <= addr[addr_w-1 -: tag_w];
            r_index  <= addr[offset_w+byte_off_w +: index_w];
            r_offset <= addr[byte_off_w +: offset_w];
            r_wdata  <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tag, valid and dirty arrays
    ////////////////////////////////////////////////////////////////////////////

    // the flush walk takes over the array index.
    assign idx = fill.index_sel ? fill.walk_index : r_index;
    assign hit = r_vld && valid_bits[r_index] && (tag_mem[r_index] == r_tag);

    always_ff @(posedge clk) begin
        if (fill.tag_wr) begin
            tag_mem[idx] <= r_tag;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_bits <= '0;
        end else if (fill.inval_all) begin
            valid_bits <= '0;
        end else if (fill.tag_wr) begin
            valid_bits[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dirty_bits <= '0;
        end else if (fill.dirty_clr) begin
            dirty_bits[idx] <= 1'b0;
        end else if (hit && (r_op == op_store)) begin
            dirty_bits[r_index] <= 1'b1;
        end
    end

    assign stage.vld        = r_vld;
    assign stage.op         = r_op;
    assign stage.index      = r_index;
    assign stage.offset     = r_offset;
    assign stage.wdata      = r_wdata;
    assign stage.hit        = hit;
    assign stage.miss       = r_vld && !hit;
    assign stage.tag        = r_tag;
    assign stage.dirty      = dirty_bits[idx];
    assign stage.stored_tag = tag_mem[idx];

endmodule

`default_nettype wire

/* rtl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int num_lines = 256;
    localparam int line_w    = 128;
    localparam int word_w    = 32;

    // address fields, msb to lsb: tag, index, word offset, byte offset.
    localparam int tag_w      = 20;
    localparam int index_w    = 8;
    localparam int offset_w   = 2;
    localparam int byte_off_w = 2;
    localparam int addr_w     = tag_w + index_w + offset_w + byte_off_w;

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////

    // risc-v load and store major opcodes.
    typedef enum logic [6:0] {
        op_none  = 7'b0000000,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        st_idle,
        st_wback,
        st_fill,
        st_replay,
        st_flush_scan,
        st_flush_wback,
        st_flush_clear
    } ctrl_state_e;

endpackage

`default_nettype wire

/* rtl/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // cpu side.
    input  logic              req,
    input  opcode_e           opcode,
    input  logic [addr_w-1:0] addr,
    input  logic [word_w-1:0] wdata,
    output logic [word_w-1:0] rdata,
    output logic              done,
    output logic              busy,
    input  logic              flush,
    output logic              flush_done,
    // memory side.
    output logic              mem_rd,
    output logic              mem_wr,
    output logic [addr_w-1:0] mem_addr,
    output logic [line_w-1:0] mem_wdata,
    input  logic [line_w-1:0] mem_rdata,
    input  logic              mem_ack
);

    stage_if u_stage ();
    fill_if  u_fill ();

    dcache_lookup u_lookup (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .opcode (opcode),
        .addr   (addr),
        .wdata  (wdata),
        .stage  (u_stage.producer),
        .fill   (u_fill.array)
    );

    dcache_data u_data (
        .clk         (clk),
        .rst         (rst),
        .stage       (u_stage.consumer),
        .fill        (u_fill.array),
        .mem_rdata   (mem_rdata),
        .rdata       (rdata),
        .done        (done),
        .victim_line (mem_wdata)
    );

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .stage      (u_stage.monitor),
        .fill       (u_fill.driver),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .busy       (busy),
        .flush_done (flush_done)
    );

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

    localparam int unsigned seed          = 32'hca6e6771;
    localparam int          num_ops       = 400;
    localparam int          step_timeout  = 200;
    localparam int          flush_timeout = 20000;
    localparam int          shadow_words  = 16384;

    logic              clk;
    logic              rst;
    logic              req;
    opcode_e           opcode;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] wdata;
    logic [word_w-1:0] rdata;
    logic              done;
    logic              busy;
    logic              flush;
    logic              flush_done;
    logic              mem_rd;
    logic              mem_wr;
    logic [addr_w-1:0] mem_addr;
    logic [line_w-1:0] mem_wdata;
    logic [line_w-1:0] mem_rdata;
    logic              mem_ack;

    logic [word_w-1:0] shadow [shadow_words];
    logic [word_w-1:0] exp_q [$];
    logic              is_load_q [$];
    int                errors;
    int                checks;
    int                tests_run;
    int                tests_failed;
    int                rd_count;
    int                wr_count;
    logic [addr_w-1:0] last_rd_addr;
    logic [addr_w-1:0] last_wr_addr;

    dcache_top u_dcache_top (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .opcode     (opcode),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .done       (done),
        .busy       (busy),
        .flush      (flush),
        .flush_done (flush_done),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack)
    );

    mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [word_w-1:0] expected_load(input logic [addr_w-1:0] a);
        return shadow[a[15:2]];
    endfunction

    // word 0 of a line sits in the low bits.
    function automatic logic [line_w-1:0] expected_line(input logic [addr_w-1:0] a);
        logic [line_w-1:0] ln;
        for (int w = 0; w < 4; w++) begin
            ln[w*word_w +: word_w] = shadow[{a[15:4], w[1:0]}];
        end
        return ln;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [addr_w-1:0] got,
                              input logic [addr_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [word_w-1:0] got,
                              input logic [word_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input logic [line_w-1:0] got,
                              input logic [line_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic expect_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("at %0t saw %0d %s, expected %0d", $time, got, what, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    // compares every load result and every write-back as it happens.
    always @(negedge clk) begin
        if (rst) begin
            if (done) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("done pulsed at %0t with no request in flight", $time);
                end else begin
                    if (is_load_q[0]) begin
                        check_word("rdata", rdata, exp_q[0]);
                    end
                    void'(exp_q.pop_front());
                    void'(is_load_q.pop_front());
                end
            end
            if (mem_ack && mem_rd) begin
                rd_count++;
                last_rd_addr = mem_addr;
            end
            if (mem_ack && mem_wr) begin
                wr_count++;
                last_wr_addr = mem_addr;
                check_line("mem_wdata", mem_wdata, expected_line(mem_addr));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < step_timeout) begin
            @(negedge clk);
            n++;
        end
        if (busy) report_timeout("busy to drop");
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < step_timeout) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) report_timeout("outstanding requests to finish");
    endtask

    task automatic issue(input opcode_e op, input logic [addr_w-1:0] a,
                         input logic [word_w-1:0] d);
        wait_idle();
        req    = 1'b1;
        opcode = op;
        addr   = a;
        wdata  = d;
        if (op == op_store) shadow[a[15:2]] = d;
        is_load_q.push_back(op == op_load);
        exp_q.push_back(expected_load(a));
        @(negedge clk);
        req    = 1'b0;
        opcode = op_none;
    endtask

    initial begin : main_seq
        int unsigned       seed_var;
        int unsigned       rnd_init;
        int                err0;
        int                rd0;
        int                wr0;
        int                n;
        logic [addr_w-1:0] a;
        seed_var = seed;
        rnd_init = $urandom(seed_var);
        rst = 1'b0;
        req = 1'b0;
        flush = 1'b0;
        opcode = op_none;
        addr = '0;
        wdata = '0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        rd_count = 0;
        wr_count = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < 4096; i++) begin
            for (int w = 0; w < 4; w++) begin
                shadow[{i[11:0], w[1:0]}] = u_mem.mem[i][w*word_w +: word_w];
            end
        end

        err0 = errors;
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("mem_rd", mem_rd, 1'b0);
        check_bit("mem_wr", mem_wr, 1'b0);
        check_bit("flush_done", flush_done, 1'b0);
        end_test("reset state", err0);

        err0 = errors;
        rd0 = rd_count;
        issue(op_load, 32'h0000_1234, '0);
        wait_drain();
        expect_count("line fills", rd_count - rd0, 1);
        check_addr("mem_addr", last_rd_addr, 32'h0000_1230);
        end_test("load miss", err0);

        err0 = errors;
        rd0 = rd_count;
        issue(op_load, 32'h0000_1238, '0);
        n = 1;
        while (!done && n < step_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!done) report_timeout("done of a load hit");
        expect_count("cycles of hit latency", n, 2);
        wait_drain();
        expect_count("line fills", rd_count - rd0, 0);
        end_test("load hit", err0);

        err0 = errors;
        rd0 = rd_count;
        wr0 = wr_count;
        issue(op_store, 32'h0000_1234, 32'h5a5a_c3c3);
        issue(op_load, 32'h0000_1234, '0);
        wait_drain();
        expect_count("memory transfers", (rd_count - rd0) + (wr_count - wr0), 0);
        end_test("store then load", err0);

        // same index, new tag, so the dirty line goes out first.
        err0 = errors;
        rd0 = rd_count;
        wr0 = wr_count;
        issue(op_load, 32'h0000_5234, '0);
        wait_drain();
        expect_count("write-backs", wr_count - wr0, 1);
        check_addr("mem_addr", last_wr_addr, 32'h0000_1230);
        expect_count("line fills", rd_count - rd0, 1);
        check_addr("mem_addr", last_rd_addr, 32'h0000_5230);
        end_test("dirty eviction", err0);

        err0 = errors;
        for (int k = 0; k < num_ops; k++) begin
            a = $urandom & 32'h0000_f0fc;
            if ($urandom % 2) begin
                issue(op_store, a, $urandom);
            end else begin
                issue(op_load, a, '0);
            end
        end
        wait_drain();
        wait_idle();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        n = 0;
        while (!flush_done && n < flush_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!flush_done) report_timeout("flush_done");
        for (int i = 0; i < 4096; i++) begin
            check_line("backing memory", u_mem.mem[i], expected_line({16'h0, i[11:0], 4'h0}));
        end
        rd0 = rd_count;
        issue(op_load, 32'h0000_5234, '0);
        wait_drain();
        expect_count("line fills after flush", rd_count - rd0, 1);
        end_test("random run and flush", err0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_rd,
    input  logic              mem_wr,
    input  logic [addr_w-1:0] mem_addr,
    input  logic [line_w-1:0] mem_wdata,
    output logic [line_w-1:0] mem_rdata,
    output logic              mem_ack
);

    localparam int mem_lines = 4096;

    // 64 KiB of backing store, one entry per cache line.
    logic [line_w-1:0] mem [mem_lines];
    logic [11:0]       line_idx;
    logic              active;
    int unsigned       wait_cnt;

    assign line_idx = mem_addr[15:4];

    initial begin
        for (int i = 0; i < mem_lines; i++) begin
            mem[i] = {$urandom, $urandom, $urandom, $urandom};
        end
    end

    // ack comes 1 to 8 cycles after the strobe is first seen.
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            active    <= 1'b0;
            wait_cnt  <= 0;
        end else if (mem_ack) begin
            mem_ack <= 1'b0;
        end else if (!active) begin
            if (mem_rd || mem_wr) begin
                active   <= 1'b1;
                wait_cnt <= $urandom % 8;
            end
        end else if (wait_cnt == 0) begin
            active  <= 1'b0;
            mem_ack <= 1'b1;
            if (mem_wr) begin
                mem[line_idx] <= mem_wdata;
            end else begin
                mem_rdata <= mem[line_idx];
            end
        end else begin
            wait_cnt <= wait_cnt - 1;
        end
    end

endmodule

`default_nettype wire
